// ==== source/video_ctrl_macros.svh ====
`ifndef VIDEO_CTRL_MACROS_SVH
`define VIDEO_CTRL_MACROS_SVH

// ------------------------------
// Wishbone host bus
// ------------------------------

// Word address, data and byte-select widths
`define WB_ADR_W 30
`define WB_DAT_W 32
`define WB_SEL_W 4

// ------------------------------
// Address map
// ------------------------------

// Word address bits compared against a region base
`define REGION_HI 29
`define REGION_LO 10

// Region bases, 1 KiW each
`define GPIO_BASE 20'h4002_1
`define OLED_BASE 20'h4002_2

// ------------------------------
// LED block
// ------------------------------

// LED register after reset, alternating pattern
`define LED_INIT 4'b0101

// Counter bit shown on the heartbeat LEDs
// Default for the board, the top level takes it as HB_BIT
`define HEARTBEAT_BIT 26

`endif

// ==== source/video_ctrl_pkg.sv ====
`include "video_ctrl_macros.svh"

package video_ctrl_pkg;

	// ------------------------------
	// Bus types
	// ------------------------------

	typedef logic [`WB_ADR_W-1:0] wb_adr_t;
	typedef logic [`WB_DAT_W-1:0] wb_dat_t;
	typedef logic [`WB_SEL_W-1:0] wb_sel_t;

	// ------------------------------
	// Pixel and LED types
	// ------------------------------

	// RGB888, red in the top byte
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} pixel24_t;

	// RGB332 as the panel takes it
	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [1:0] b;
	} pixel8_t;

	typedef logic [3:0] led_t;

	// ------------------------------
	// Register map enums
	// ------------------------------

	typedef enum logic [1:0] {REGION_NONE, REGION_GPIO, REGION_OLED} wb_region_e;

	// Word offsets inside a region
	typedef enum logic [1:0] {GPIO_LED_OUT = 2'd0, GPIO_DIP_IN = 2'd1} gpio_reg_e;
	typedef enum logic [1:0] {OLED_CTRL = 2'd0, OLED_FRAME_CNT = 2'd1} oled_reg_e;

endpackage

// ==== source/wb_addr_decoder.sv ====
`include "video_ctrl_macros.svh"

module wb_addr_decoder
	import video_ctrl_pkg::*;
	(
		input  logic    core_clk,
		input  logic    rst_n_i,

		// Host side
		input  wb_adr_t wb_adr_i,
		input  logic    wb_stb_i,
		output wb_dat_t wb_dat_o,
		output logic    wb_ack_o,

		// Register blocks
		output logic    gpio_stb_o,
		input  wb_dat_t gpio_dat_i,
		input  logic    gpio_ack_i,
		output logic    oled_stb_o,
		input  wb_dat_t oled_dat_i,
		input  logic    oled_ack_i
	);

	wb_region_e region;

	// Region from the upper word address bits
	always_comb begin
		region = REGION_NONE;
		if (wb_adr_i[`REGION_HI:`REGION_LO] == `GPIO_BASE) begin
			region = REGION_GPIO;
		end else if (wb_adr_i[`REGION_HI:`REGION_LO] == `OLED_BASE) begin
			region = REGION_OLED;
		end
	end

	assign gpio_stb_o = wb_stb_i && (region == REGION_GPIO);
	assign oled_stb_o = wb_stb_i && (region == REGION_OLED);

	// Return path
	// Unmapped space answers at once with zero so the host never hangs
	always_comb begin
		case (region)
			REGION_GPIO: begin
				wb_dat_o = gpio_dat_i;
				wb_ack_o = gpio_ack_i;
			end
			REGION_OLED: begin
				wb_dat_o = oled_dat_i;
				wb_ack_o = oled_ack_i;
			end
			default: begin
				wb_dat_o = '0;
				wb_ack_o = wb_stb_i;
			end
		endcase
	end

	// Only one block may see a cycle
	a_stb_excl: assert property (@(posedge core_clk) disable iff (!rst_n_i)
		!(gpio_stb_o && oled_stb_o))
		else $error("GPIO and OLED strobes both active");

endmodule

// ==== source/gpio_led_regs.sv ====
`include "video_ctrl_macros.svh"

module gpio_led_regs
	import video_ctrl_pkg::*;
	#(
		parameter int HB_BIT = `HEARTBEAT_BIT
	)
	(
		input  logic       core_clk,
		input  logic       rst_n_i,

		// Wishbone slave, word offset only
		input  logic       stb_i,
		input  logic       we_i,
		input  wb_sel_t    sel_i,
		input  logic [1:0] adr_i,
		input  wb_dat_t    dat_i,
		output wb_dat_t    dat_o,
		output logic       ack_o,

		// Board IO
		input  logic [3:0] dip_sw_i,
		output led_t       led_o
	);

	logic          ack_q;
	logic          acc_start;
	led_t          led_q;
	wb_dat_t       dat_q;
	logic [HB_BIT:0] hb_cnt;

	// ------------------------------
	// Register access
	// ------------------------------

	// First cycle of a strobe, the ack edge
	assign acc_start = stb_i && !ack_q;

	// One-cycle ack
	always_ff @(posedge core_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= acc_start;
		end
	end

	// LED register, byte lane 0 only
	always_ff @(posedge core_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			led_q <= `LED_INIT;
		end else if (acc_start && we_i && sel_i[0] && (gpio_reg_e'(adr_i) == GPIO_LED_OUT)) begin
			led_q <= dat_i[3:0];
		end
	end

	// Read data sampled with the ack
	always_ff @(posedge core_clk) begin
		if (acc_start) begin
			case (gpio_reg_e'(adr_i))
				GPIO_LED_OUT: dat_q <= wb_dat_t'(led_q);
				GPIO_DIP_IN:  dat_q <= wb_dat_t'(dip_sw_i);
				default:      dat_q <= '0;
			endcase
		end
	end

	assign dat_o = dat_q;
	assign ack_o = ack_q;

	// ------------------------------
	// Heartbeat
	// ------------------------------

	// Free-running, never cleared after reset
	always_ff @(posedge core_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			hb_cnt <= '0;
		end else begin
			hb_cnt <= hb_cnt + 1'b1;
		end
	end

	// Low LEDs from software, high pair blinks
	assign led_o = {hb_cnt[HB_BIT], hb_cnt[HB_BIT], led_q[1:0]};

	// Host must idle between strobes, so ack never stretches
	a_ack_pulse: assert property (@(posedge core_clk) disable iff (!rst_n_i)
		ack_o |=> !ack_o)
		else $error("GPIO ack longer than one cycle");

endmodule

// ==== source/pixel_rgb332_cnv.sv ====
module pixel_rgb332_cnv
	import video_ctrl_pkg::*;
	(
		input  logic     core_clk,
		input  logic     rst_n_i,

		// RGB888 stream in
		input  pixel24_t s_data_i,
		input  logic     s_user_i,
		input  logic     s_last_i,
		input  logic     s_valid_i,
		output logic     s_ready_o,

		// RGB332 stream out
		output pixel8_t  m_data_o,
		output logic     m_user_o,
		output logic     m_last_o,
		output logic     m_valid_o,
		input  logic     m_ready_i
	);

	logic    m_valid_q;
	pixel8_t m_data_q;
	logic    m_user_q;
	logic    m_last_q;

	// Accept when the stage is empty or drains this cycle
	assign s_ready_o = !m_valid_q || m_ready_i;

	always_ff @(posedge core_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			m_valid_q <= 1'b0;
		end else if (s_ready_o) begin
			m_valid_q <= s_valid_i;
		end
	end

	// Truncate to the top bits of each channel
	always_ff @(posedge core_clk) begin
		if (s_valid_i && s_ready_o) begin
			m_data_q.r <= s_data_i.r[7:5];
			m_data_q.g <= s_data_i.g[7:5];
			m_data_q.b <= s_data_i.b[7:6];
			m_user_q   <= s_user_i;
			m_last_q   <= s_last_i;
		end
	end

	assign m_data_o  = m_data_q;
	assign m_user_o  = m_user_q;
	assign m_last_o  = m_last_q;
	assign m_valid_o = m_valid_q;

	// Stalled beat must hold
	a_hold_data: assert property (@(posedge core_clk) disable iff (!rst_n_i)
		(m_valid_o && !m_ready_i) |=> $stable(m_data_o))
		else $error("RGB332 data changed under back-pressure");

endmodule

// ==== source/oled_stream_ctrl.sv ====
module oled_stream_ctrl
	import video_ctrl_pkg::*;
	(
		input  logic       core_clk,
		input  logic       rst_n_i,

		// Wishbone slave, word offset only
		input  logic       stb_i,
		input  logic       we_i,
		input  wb_sel_t    sel_i,
		input  logic [1:0] adr_i,
		input  wb_dat_t    dat_i,
		output wb_dat_t    dat_o,
		output logic       ack_o,

		// RGB332 stream from the converter
		input  pixel8_t    s_data_i,
		input  logic       s_user_i,
		input  logic       s_last_i,
		input  logic       s_valid_i,
		output logic       s_ready_o,

		// Panel side
		output pixel8_t    oled_data_o,
		output logic       oled_user_o,
		output logic       oled_last_o,
		output logic       oled_valid_o,
		input  logic       oled_ready_i
	);

	logic    ack_q;
	logic    acc_start;
	logic    enable_q;
	wb_dat_t frame_cnt_q;
	wb_dat_t dat_q;

	// ------------------------------
	// Control registers
	// ------------------------------

	assign acc_start = stb_i && !ack_q;

	always_ff @(posedge core_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ack_q    <= 1'b0;
			enable_q <= 1'b0;
		end else begin
			ack_q <= acc_start;
			// Frame counter offset is read-only
			if (acc_start && we_i && sel_i[0] && (oled_reg_e'(adr_i) == OLED_CTRL)) begin
				enable_q <= dat_i[0];
			end
		end
	end

	always_ff @(posedge core_clk) begin
		if (acc_start) begin
			case (oled_reg_e'(adr_i))
				OLED_CTRL:      dat_q <= wb_dat_t'(enable_q);
				OLED_FRAME_CNT: dat_q <= frame_cnt_q;
				default:        dat_q <= '0;
			endcase
		end
	end

	assign dat_o = dat_q;
	assign ack_o = ack_q;

	// ------------------------------
	// Stream gate
	// ------------------------------

	// Disabled path sinks everything so the converter keeps draining
	assign oled_data_o  = s_data_i;
	assign oled_user_o  = s_user_i;
	assign oled_last_o  = s_last_i;
	assign oled_valid_o = s_valid_i && enable_q;
	assign s_ready_o    = enable_q ? oled_ready_i : 1'b1;

	// One count per start-of-frame beat that reaches the panel
	always_ff @(posedge core_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			frame_cnt_q <= '0;
		end else if (oled_valid_o && oled_ready_i && s_user_i) begin
			frame_cnt_q <= frame_cnt_q + 1'b1;
		end
	end

endmodule

// ==== source/video_ctrl_top.sv ====
`include "video_ctrl_macros.svh"

module video_ctrl_top
	import video_ctrl_pkg::*;
	#(
		parameter int HB_BIT = `HEARTBEAT_BIT
	)
	(
		input  logic       core_clk,
		input  logic       rst_n_i,

		// Wishbone host
		input  wb_adr_t    wb_adr_i,
		input  wb_dat_t    wb_dat_i,
		input  logic       wb_we_i,
		input  wb_sel_t    wb_sel_i,
		input  logic       wb_stb_i,
		output wb_dat_t    wb_dat_o,
		output logic       wb_ack_o,

		// Board IO
		input  logic [3:0] dip_sw_i,
		output led_t       led_o,

		// Pixel stream in
		input  pixel24_t   pix_data_i,
		input  logic       pix_user_i,
		input  logic       pix_last_i,
		input  logic       pix_valid_i,
		output logic       pix_ready_o,

		// OLED stream out
		output pixel8_t    oled_data_o,
		output logic       oled_user_o,
		output logic       oled_last_o,
		output logic       oled_valid_o,
		input  logic       oled_ready_i
	);

	// ------------------------------
	// Bus fabric
	// ------------------------------

	wb_dat_t gpio_dat;
	logic    gpio_stb;
	logic    gpio_ack;
	wb_dat_t oled_dat;
	logic    oled_stb;
	logic    oled_ack;

	wb_addr_decoder u_dec (
		.core_clk   (core_clk),
		.rst_n_i    (rst_n_i),
		.wb_adr_i   (wb_adr_i),
		.wb_stb_i   (wb_stb_i),
		.wb_dat_o   (wb_dat_o),
		.wb_ack_o   (wb_ack_o),
		.gpio_stb_o (gpio_stb),
		.gpio_dat_i (gpio_dat),
		.gpio_ack_i (gpio_ack),
		.oled_stb_o (oled_stb),
		.oled_dat_i (oled_dat),
		.oled_ack_i (oled_ack)
	);

	// Blocks see only the word offset
	gpio_led_regs #(.HB_BIT(HB_BIT)) u_gpio (
		.core_clk (core_clk),
		.rst_n_i  (rst_n_i),
		.stb_i    (gpio_stb),
		.we_i     (wb_we_i),
		.sel_i    (wb_sel_i),
		.adr_i    (wb_adr_i[1:0]),
		.dat_i    (wb_dat_i),
		.dat_o    (gpio_dat),
		.ack_o    (gpio_ack),
		.dip_sw_i (dip_sw_i),
		.led_o    (led_o)
	);

	// ------------------------------
	// Video path
	// ------------------------------

	pixel8_t cnv_data;
	logic    cnv_user;
	logic    cnv_last;
	logic    cnv_valid;
	logic    cnv_ready;

	pixel_rgb332_cnv u_cnv (
		.core_clk  (core_clk),
		.rst_n_i   (rst_n_i),
		.s_data_i  (pix_data_i),
		.s_user_i  (pix_user_i),
		.s_last_i  (pix_last_i),
		.s_valid_i (pix_valid_i),
		.s_ready_o (pix_ready_o),
		.m_data_o  (cnv_data),
		.m_user_o  (cnv_user),
		.m_last_o  (cnv_last),
		.m_valid_o (cnv_valid),
		.m_ready_i (cnv_ready)
	);

	oled_stream_ctrl u_oled (
		.core_clk     (core_clk),
		.rst_n_i      (rst_n_i),
		.stb_i        (oled_stb),
		.we_i         (wb_we_i),
		.sel_i        (wb_sel_i),
		.adr_i        (wb_adr_i[1:0]),
		.dat_i        (wb_dat_i),
		.dat_o        (oled_dat),
		.ack_o        (oled_ack),
		.s_data_i     (cnv_data),
		.s_user_i     (cnv_user),
		.s_last_i     (cnv_last),
		.s_valid_i    (cnv_valid),
		.s_ready_o    (cnv_ready),
		.oled_data_o  (oled_data_o),
		.oled_user_o  (oled_user_o),
		.oled_last_o  (oled_last_o),
		.oled_valid_o (oled_valid_o),
		.oled_ready_i (oled_ready_i)
	);

endmodule

// ==== sim/video_ctrl_tb.sv ====
`include "video_ctrl_macros.svh"

module video_ctrl_tb
	import video_ctrl_pkg::*;
	#(
		// Fast heartbeat, bit 4 toggles every 16 cycles
		parameter int HB_BIT = 4
	);

	typedef enum logic [1:0] {OP_WR, OP_RD, OP_PIX, OP_LED} op_e;

	// One table row, pixel in dat[23:0] and last in dat[24]
	// Expected RGB332 in exp[7:0], user and last in exp[9:8]
	typedef struct {
		op_e     op;
		wb_adr_t adr;
		wb_sel_t sel;
		wb_dat_t dat;
		logic    user;
		wb_dat_t exp;
	} entry_t;

	localparam wb_adr_t    ADR_LED  = {`GPIO_BASE, 8'd0, GPIO_LED_OUT};
	localparam wb_adr_t    ADR_DIP  = {`GPIO_BASE, 8'd0, GPIO_DIP_IN};
	localparam wb_adr_t    ADR_CTRL = {`OLED_BASE, 8'd0, OLED_CTRL};
	localparam wb_adr_t    ADR_FCNT = {`OLED_BASE, 8'd0, OLED_FRAME_CNT};
	localparam wb_adr_t    ADR_NONE = {20'h1234_5, 10'd4};
	localparam logic [3:0] DIP_VAL  = 4'b1001;

	logic       core_clk = 1'b0;
	logic       rst_n_i;
	wb_adr_t    wb_adr_i;
	wb_dat_t    wb_dat_i;
	logic       wb_we_i;
	wb_sel_t    wb_sel_i;
	logic       wb_stb_i;
	wb_dat_t    wb_dat_o;
	logic       wb_ack_o;
	logic [3:0] dip_sw_i;
	led_t       led_o;
	pixel24_t   pix_data_i;
	logic       pix_user_i;
	logic       pix_last_i;
	logic       pix_valid_i;
	logic       pix_ready_o;
	pixel8_t    oled_data_o;
	logic       oled_user_o;
	logic       oled_last_o;
	logic       oled_valid_o;
	logic       oled_ready_i;

	entry_t       tbl[$];
	wb_dat_t      exp_q[$];
	integer       seed;
	logic         stream_en;
	logic [255:0] rdy_a;
	logic [255:0] rdy_b;
	logic [7:0]   rdy_idx;
	int           cycle_cnt = 0;
	int           max_cycles = 0;

	video_ctrl_top #(.HB_BIT(HB_BIT)) uut (.*);

	always #10 core_clk = ~core_clk;

	// ------------------------------
	// Reporting and compare tasks
	// ------------------------------

	task automatic stop_on_error(input string line);
		$display("%s", line);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_dat(input wb_dat_t got, input wb_dat_t exp, input string what);
		if (got !== exp) begin
			stop_on_error($sformatf("CHECK FAILED at time %0t: %s gave %h, expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_pix(input pixel8_t got, input pixel8_t exp, input string what);
		if (got !== exp) begin
			stop_on_error($sformatf("CHECK FAILED at time %0t: %s gave %h, expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_led(input led_t got, input led_t exp, input string what);
		if (got !== exp) begin
			stop_on_error($sformatf("CHECK FAILED at time %0t: %s gave %b, expected %b",
				$time, what, got, exp));
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			stop_on_error($sformatf("CHECK FAILED at time %0t: %s gave %b, expected %b",
				$time, what, got, exp));
		end
	endtask

	// Top 3 bits of red and green, top 2 of blue
	function automatic pixel8_t to_rgb332(input pixel24_t px);
		return pixel8_t'({px[23:21], px[15:13], px[7:6]});
	endfunction

	// ------------------------------
	// Stimulus table
	// ------------------------------

	task automatic add_entry(input op_e op, input wb_adr_t adr, input wb_sel_t sel,
		input wb_dat_t dat, input logic user, input wb_dat_t exp);
		entry_t e;
		e.op   = op;
		e.adr  = adr;
		e.sel  = sel;
		e.dat  = dat;
		e.user = user;
		e.exp  = exp;
		tbl.push_back(e);
	endtask

	task automatic build_table();
		integer   r;
		pixel24_t px;
		logic     usr;
		int       frames;
		frames = 0;
		// Ready pattern for the panel side, high about 3 cycles in 4
		for (int k = 0; k < 8; k++) begin
			rdy_a = {rdy_a[223:0], $random(seed)};
			rdy_b = {rdy_b[223:0], $random(seed)};
		end
		add_entry(OP_RD, ADR_LED, 4'hF, '0, 1'b0, {28'd0, `LED_INIT});
		add_entry(OP_LED, '0, '0, '0, 1'b0, 32'h1);
		add_entry(OP_WR, ADR_LED, 4'h1, 32'h6, 1'b0, '0);
		add_entry(OP_LED, '0, '0, '0, 1'b0, 32'h2);
		// Lane 0 off, register must keep 6
		add_entry(OP_WR, ADR_LED, 4'hE, 32'h1, 1'b0, '0);
		add_entry(OP_LED, '0, '0, '0, 1'b0, 32'h2);
		add_entry(OP_RD, ADR_LED, 4'hF, '0, 1'b0, 32'h6);
		add_entry(OP_RD, ADR_DIP, 4'hF, '0, 1'b0, {28'd0, DIP_VAL});
		add_entry(OP_RD, ADR_NONE, 4'hF, '0, 1'b0, 32'h0);
		add_entry(OP_RD, ADR_CTRL, 4'hF, '0, 1'b0, 32'h0);
		add_entry(OP_WR, ADR_CTRL, 4'h1, 32'h1, 1'b0, '0);
		add_entry(OP_RD, ADR_CTRL, 4'hF, '0, 1'b0, 32'h1);
		// Enabled stream, a few start-of-frame beats
		for (int i = 0; i < 200; i++) begin
			r = $random(seed);
			px = pixel24_t'(r[23:0]);
			usr = (i == 0) || (($random(seed) & 15) == 0);
			if (usr) begin
				frames++;
			end
			add_entry(OP_PIX, '0, '0, {7'h00, r[24], px}, usr,
				{22'h0, r[24], usr, to_rgb332(px)});
		end
		add_entry(OP_WR, ADR_CTRL, 4'h1, 32'h0, 1'b0, '0);
		// Disabled, start-of-frame beats are dropped and not counted
		for (int i = 0; i < 8; i++) begin
			r = $random(seed);
			px = pixel24_t'(r[23:0]);
			add_entry(OP_PIX, '0, '0, {7'h00, r[24], px}, 1'b1, '0);
		end
		add_entry(OP_RD, ADR_FCNT, 4'hF, '0, 1'b0, wb_dat_t'(frames));
	endtask

	// ------------------------------
	// Bus and stream drivers
	// ------------------------------

	task automatic wb_access(input logic we, input wb_adr_t adr, input wb_sel_t sel,
		input wb_dat_t wdat, output wb_dat_t rdat);
		int waits;
		waits = 0;
		@(negedge core_clk);
		wb_adr_i = adr;
		wb_we_i  = we;
		wb_sel_i = sel;
		wb_dat_i = wdat;
		wb_stb_i = 1'b1;
		#1;
		while (!wb_ack_o) begin
			waits++;
			if (waits > 8) begin
				stop_on_error($sformatf("No ack from address %h within 8 cycles", adr));
			end
			@(negedge core_clk);
			#1;
		end
		rdat = wb_dat_o;
		// Release after the ack, leaves one idle cycle
		@(negedge core_clk);
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
	endtask

	task automatic send_pixel(input entry_t e);
		int waits;
		waits = 0;
		@(negedge core_clk);
		pix_data_i  = pixel24_t'(e.dat[23:0]);
		pix_user_i  = e.user;
		pix_last_i  = e.dat[24];
		pix_valid_i = 1'b1;
		#1;
		while (!pix_ready_o) begin
			if (!stream_en) begin
				stop_on_error($sformatf("CHECK FAILED at time %0t: pix_ready_o low while disabled",
					$time));
			end
			waits++;
			if (waits > 50) begin
				stop_on_error("Pixel input stalled for more than 50 cycles");
			end
			@(negedge core_clk);
			#1;
		end
		// Beat transfers at the next rising edge
		if (stream_en) begin
			exp_q.push_back(e.exp);
		end
	endtask

	task automatic drain_wait();
		int waits;
		waits = 0;
		@(negedge core_clk);
		pix_valid_i = 1'b0;
		while (exp_q.size() != 0) begin
			waits++;
			if (waits > 50) begin
				stop_on_error("Pixels still missing at the OLED output after 50 cycles");
			end
			@(negedge core_clk);
		end
	endtask

	task automatic run_entry(input entry_t e);
		wb_dat_t rdat;
		case (e.op)
			OP_WR: begin
				drain_wait();
				wb_access(1'b1, e.adr, e.sel, e.dat, rdat);
				if (e.adr == ADR_CTRL && e.sel[0]) begin
					stream_en = e.dat[0];
				end
			end
			OP_RD: begin
				drain_wait();
				wb_access(1'b0, e.adr, e.sel, '0, rdat);
				check_dat(rdat, e.exp, $sformatf("read of %h", e.adr));
			end
			OP_PIX: send_pixel(e);
			OP_LED: begin
				@(negedge core_clk);
				check_led({2'b00, led_o[1:0]}, {2'b00, e.exp[1:0]}, "led_o bits 1..0");
			end
		endcase
	endtask

	// Find one toggle, then expect two periods of 16 cycles
	task automatic heartbeat_test();
		led_t prev;
		led_t cur;
		int   waits;
		waits = 0;
		@(negedge core_clk);
		prev = led_o;
		cur = prev;
		while (cur[3:2] == prev[3:2]) begin
			@(negedge core_clk);
			cur = led_o;
			waits++;
			if (waits > 40) begin
				stop_on_error("Heartbeat LEDs did not change within 40 cycles");
			end
		end
		repeat (2) begin
			prev = cur;
			check_led({cur[3:2], 2'b00}, {cur[3], cur[3], 2'b00}, "heartbeat pair");
			repeat (15) begin
				@(negedge core_clk);
				cur = led_o;
				check_led(cur, prev, "heartbeat hold");
			end
			@(negedge core_clk);
			cur = led_o;
			check_led(cur, {~prev[3], ~prev[2], prev[1:0]}, "heartbeat toggle");
		end
	endtask

	// ------------------------------
	// Processes
	// ------------------------------

	// Panel side, random ready and in-order compare
	initial begin
		wb_dat_t want;
		oled_ready_i = 1'b1;
		rdy_idx = '0;
		forever begin
			@(negedge core_clk);
			if (rst_n_i) begin
				oled_ready_i = rdy_a[rdy_idx] | rdy_b[rdy_idx];
				rdy_idx = rdy_idx + 8'd1;
			end
			#1;
			if (oled_valid_o && exp_q.size() == 0) begin
				stop_on_error($sformatf("CHECK FAILED at time %0t: oled_valid_o with no beat pending",
					$time));
			end
			if (oled_valid_o && oled_ready_i) begin
				want = exp_q.pop_front();
				check_pix(oled_data_o, pixel8_t'(want[7:0]), "OLED pixel");
				check_flag(oled_user_o, want[8], "OLED user flag");
				check_flag(oled_last_o, want[9], "OLED last flag");
			end
		end
	end

	always @(posedge core_clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (max_cycles > 0 && cycle_cnt > max_cycles) begin
			stop_on_error($sformatf("Run hit the limit of %0d cycles", max_cycles));
		end
	end

	initial begin
		rst_n_i     = 1'b0;
		wb_adr_i    = '0;
		wb_dat_i    = '0;
		wb_we_i     = 1'b0;
		wb_sel_i    = '0;
		wb_stb_i    = 1'b0;
		dip_sw_i    = DIP_VAL;
		pix_data_i  = '0;
		pix_user_i  = 1'b0;
		pix_last_i  = 1'b0;
		pix_valid_i = 1'b0;
		stream_en   = 1'b0;
		seed        = 24791;
		build_table();
		max_cycles = 50 * tbl.size() + 200;
		repeat (3) @(negedge core_clk);
		rst_n_i = 1'b1;
		foreach (tbl[i]) begin
			run_entry(tbl[i]);
		end
		drain_wait();
		heartbeat_test();
		$display("Simulation passed");
		$finish;
	end

endmodule

// ==== video_ctrl.f ====
+incdir+source
source/video_ctrl_pkg.sv
source/wb_addr_decoder.sv
source/gpio_led_regs.sv
source/pixel_rgb332_cnv.sv
source/oled_stream_ctrl.sv
source/video_ctrl_top.sv
sim/video_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the video_ctrl testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert \
	--top-module video_ctrl_tb \
	-f video_ctrl.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/Vvideo_ctrl_tb > "$log" 2>&1
status=$?
cat "$log"

# Verdict comes from the log
if grep -q "Simulation failed" "$log"; then
	echo "Result: FAIL"
	exit 1
fi

if [ $status -ne 0 ]; then
	echo "Simulation run exited with status $status"
	exit 1
fi

echo "Result: PASS"
exit 0
